// ==== Bender.yml ====
package:
  name: dircc_node

sources:
  - verilog/dircc_types_pkg.sv
  - verilog/dircc_msg_if.sv
  - verilog/dircc_status_register.sv
  - verilog/dircc_msg_fifo.sv
  - verilog/dircc_device_core.sv
  - verilog/dircc_node.sv
  - target: test
    files:
      - test/dircc_node_props.sv
      - test/dircc_node_tb.sv

// ==== project.f ====
verilog/dircc_types_pkg.sv
verilog/dircc_msg_if.sv
verilog/dircc_status_register.sv
verilog/dircc_msg_fifo.sv
verilog/dircc_device_core.sv
verilog/dircc_node.sv
test/dircc_node_props.sv
test/dircc_node_tb.sv

// ==== test/dircc_node_props.sv ====
`timescale 1ns/1ps

module dircc_node_props (
    input logic                         clk,
    input logic                         reset_n,
    input logic                         in_ready,
    input logic                         out_valid,
    input logic                         out_ready,
    input logic [15:0]                  out_src,
    input logic [63:0]                  out_payload,
    input logic                         write_state_valid,
    input dircc_types_pkg::core_state_t core_state
);

    import dircc_types_pkg::*;

    int fail_count = 0;   // Failed assertions so far

    // Quiet outputs and idle core while in reset
    reset_quiet: assert property (@(posedge clk)
        !reset_n |-> !out_valid && !write_state_valid && !in_ready && core_state == st_idle)
    else begin
        $error("Node active during reset");
        fail_count++;
    end

    reply_hold: assert property (@(posedge clk) disable iff (!reset_n)
        out_valid && !out_ready |=> out_valid && $stable(out_src) && $stable(out_payload))
    else begin
        $error("Reply dropped or changed before out_ready");
        fail_count++;
    end

    // One write-back per message
    single_writeback: assert property (@(posedge clk) disable iff (!reset_n)
        write_state_valid |=> !write_state_valid)
    else begin
        $error("Write-back high in two consecutive cycles");
        fail_count++;
    end

endmodule : dircc_node_props

bind dircc_node dircc_node_props i_props (
    .clk               (clk),
    .reset_n           (reset_n),
    .in_ready          (in_ready),
    .out_valid         (out_valid),
    .out_ready         (out_ready),
    .out_src           (out_src),
    .out_payload       (out_payload),
    .write_state_valid (write_state_valid),
    .core_state        (i_core.state)
);

// ==== test/dircc_node_tb.sv ====
`timescale 1ns/1ps

module dircc_node_tb;

    import dircc_types_pkg::*;

    localparam int timeout_cycles = 50;

    logic        clk;
    logic        reset_n;
    logic        in_valid;
    logic        in_ready;
    msg_op_t     in_op;
    logic [15:0] in_src;
    logic [63:0] in_payload;
    logic        out_valid;
    logic        out_ready;
    logic [15:0] out_src;
    logic [63:0] out_payload;
    logic [14:0] mem_address;
    logic        mem_write;
    logic [15:0] mem_writedata;
    logic [15:0] mem_readdata;

    // Reference model of the state record
    logic [15:0] exp_count;
    logic [15:0] exp_src;
    logic [63:0] exp_acc;
    logic [7:0]  host_bytes [12];   // Expected register bytes for host tests

    integer seed = 32'he2c9_8f71;
    int     test_errors;
    int     tests_passed;
    int     tests_failed;

    dircc_node #(
        .ADDRESS_WIDTH (15),
        .FIFO_DEPTH    (4)
    ) i_dut (.*);

    always #50 clk = ~clk;

    task automatic check_val(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("** Error at %0t ns: %s expected %h, got %h",
                     $time, name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic note_timeout(input string what);
        $display("Timed out at %0t ns waiting for %s", $time, what);
        test_errors++;
    endtask

    task automatic end_test(input string name);
        if (test_errors == 0) begin
            tests_passed++;
            $display("Test %s passed", name);
        end else begin
            tests_failed++;
            $display("Test %s failed with %0d mismatches", name, test_errors);
        end
        test_errors = 0;
    endtask

    // One accepted message applied to the model
    function automatic void model_update(input msg_op_t op, input logic [15:0] src,
                                         input logic [63:0] payload);
        exp_count = exp_count + 16'd1;
        exp_src   = src;
        case (op)
            op_add:   exp_acc = exp_acc + payload;
            op_max:   exp_acc = (payload > exp_acc) ? payload : exp_acc;
            op_clear: exp_acc = '0;
            default:  ;   // Read leaves it alone
        endcase
    endfunction

    task automatic send_msg(input msg_op_t op, input logic [15:0] src,
                            input logic [63:0] payload);
        int waited;
        @(negedge clk);
        in_valid   = 1'b1;
        in_op      = op;
        in_src     = src;
        in_payload = payload;
        waited     = 0;
        while (!in_ready && waited < timeout_cycles) begin
            @(negedge clk);
            waited++;
        end
        if (in_ready) begin
            model_update(op, src, payload);   // Transfer on the coming edge
        end else begin
            note_timeout("in_ready");
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic host_write(input int addr, input logic [15:0] data);
        @(negedge clk);
        mem_address   = 15'(addr);
        mem_write     = 1'b1;
        mem_writedata = data;
        @(negedge clk);
        mem_write = 1'b0;
        if (addr <= 10) begin
            host_bytes[addr]     = data[7:0];
            host_bytes[addr + 1] = data[15:8];
        end
    endtask

    task automatic host_read(input int addr, output logic [15:0] data);
        @(negedge clk);
        mem_address = 15'(addr);
        mem_write   = 1'b0;
        @(negedge clk);
        data = mem_readdata;   // Registered one cycle after the address
    endtask

    task automatic check_record();
        logic [15:0] word;
        logic [63:0] acc;
        host_read(0, word);
        check_val("count", exp_count, word);
        host_read(2, word);
        check_val("last src", exp_src, word);
        for (int i = 0; i < 4; i++) begin
            host_read(4 + 2 * i, word);
            acc[16*i +: 16] = word;
        end
        check_val("accumulator", exp_acc, acc);
    endtask

    // Queue empty and core back in idle
    task automatic wait_drained();
        int waited;
        waited = 0;
        while (!(i_dut.i_core.state == st_idle && !i_dut.q_if.valid)
               && waited < timeout_cycles) begin
            @(negedge clk);
            waited++;
        end
        if (!(i_dut.i_core.state == st_idle && !i_dut.q_if.valid)) begin
            note_timeout("the node to drain");
        end
    endtask

    task automatic wait_out_valid();
        int waited;
        waited = 0;
        while (!out_valid && waited < timeout_cycles) begin
            @(negedge clk);
            waited++;
        end
        if (!out_valid) begin
            note_timeout("out_valid");
        end
    endtask

    initial begin
        logic [15:0] rd;
        logic [15:0] data;
        logic [31:0] r;
        msg_op_t     op;
        int          waited;
        int          accepted;
        clk           = 1'b0;
        reset_n       = 1'b0;
        in_valid      = 1'b0;
        in_op         = op_add;
        in_src        = '0;
        in_payload    = '0;
        out_ready     = 1'b1;
        mem_address   = '0;
        mem_write     = 1'b0;
        mem_writedata = '0;
        exp_count     = '0;
        exp_src       = '0;
        exp_acc       = '0;
        test_errors   = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        for (int i = 0; i < 12; i++) begin
            host_bytes[i] = '0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        for (int a = 0; a <= 10; a += 2) begin
            host_read(a, rd);
            check_val("mem_readdata", 16'h0000, rd);
        end
        check_val("out_valid", 1'b0, out_valid);
        end_test("reset values");

        for (int a = 0; a <= 10; a += 2) begin
            data = 16'h5a0f + 16'(a) * 16'h0321;
            host_write(a, data);
            host_read(a, rd);
            check_val("mem_readdata", data, rd);
        end
        host_write(3, 16'ha55a);   // Touches bytes 3 and 4 only
        for (int a = 0; a <= 10; a += 2) begin
            host_read(a, rd);
            check_val("mem_readdata", {host_bytes[a + 1], host_bytes[a]}, rd);
        end
        for (int a = 11; a < 14; a++) begin
            host_read(a, rd);
            check_val("mem_readdata", 16'h0000, rd);
        end
        for (int a = 0; a <= 10; a += 2) begin
            host_write(a, 16'h0000);
        end
        end_test("host access");

        repeat (20) begin
            r  = $random(seed);
            op = msg_op_t'(2'(r % 3));
            send_msg(op, r[31:16], {$random(seed), $random(seed)});
        end
        wait_drained();
        check_record();
        end_test("random messages");

        out_ready = 1'b0;
        send_msg(op_read, 16'h0a5c, '0);
        wait_out_valid();
        repeat (4) @(negedge clk);   // Reply held under back-pressure
        check_val("out_valid", 1'b1, out_valid);
        check_val("out_src", 16'h0a5c, out_src);
        check_val("out_payload", exp_acc, out_payload);
        out_ready = 1'b1;
        wait_drained();
        check_record();
        end_test("read reply");

        out_ready = 1'b0;
        send_msg(op_read, 16'h0b00, '0);
        wait_out_valid();
        accepted = 0;
        while (in_ready && accepted < 12) begin
            r = $random(seed);
            send_msg(op_add, r[15:0], 64'(r));
            accepted++;
        end
        check_val("in_ready", 1'b0, in_ready);
        check_val("accepted", 4, accepted);
        out_ready = 1'b1;
        wait_drained();
        check_record();
        end_test("queue full");

        send_msg(op_add, 16'h0c01, 64'h1234);
        waited = 0;
        while (!i_dut.write_state_valid && waited < timeout_cycles) begin
            @(negedge clk);
            waited++;
        end
        if (!i_dut.write_state_valid) begin
            note_timeout("the write-back cycle");
        end else begin
            mem_address   = 4;
            mem_write     = 1'b1;   // Same edge as the write-back
            mem_writedata = 16'hbeef;
            @(negedge clk);
            mem_write = 1'b0;
        end
        wait_drained();
        check_record();
        end_test("write collision");

        test_errors = i_dut.i_props.fail_count;
        end_test("bound assertions");

        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule : dircc_node_tb

// ==== verilog/dircc_device_core.sv ====
`timescale 1ns/1ps

module dircc_device_core (
    input  logic                                      clk,
    input  logic                                      reset_n,

    dircc_msg_if.consumer                             msg_in,

    input  dircc_types_pkg::device_state_t            read_state,
    output dircc_types_pkg::device_state_t            write_state,
    output logic                                      write_state_valid,

    output logic                                      out_valid,
    input  logic                                      out_ready,
    output logic [dircc_types_pkg::src_width-1:0]     out_src,
    output logic [dircc_types_pkg::payload_width-1:0] out_payload
);

    import dircc_types_pkg::*;

    core_state_t              state;
    core_state_t              state_next;
    msg_t                     msg_q;          // Message being executed
    logic [payload_width-1:0] reply_payload;  // Accumulator for the reply

    assign msg_in.ready      = (state == st_idle);
    assign write_state_valid = (state == st_exec);
    assign out_valid         = (state == st_send);
    assign out_src           = msg_q.src;
    assign out_payload       = reply_payload;

    // New record from current state and latched message
    always_comb begin
        write_state                   = read_state;
        write_state.dircc_state       = read_state.dircc_state + 16'd1;
        write_state.dircc_state_extra = msg_q.src;
        case (msg_q.op)
            op_add: begin
                write_state.user_state = read_state.user_state + msg_q.payload;
            end
            op_max: begin
                if (msg_q.payload > read_state.user_state) begin
                    write_state.user_state = msg_q.payload;
                end
            end
            op_clear: begin
                write_state.user_state = '0;
            end
            default: ;   // op_read keeps the accumulator
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (msg_in.valid) begin
                    state_next = st_exec;
                end
            end
            st_exec: begin
                if (msg_q.op == op_read) begin
                    state_next = st_send;
                end else begin
                    state_next = st_idle;
                end
            end
            st_send: begin
                if (out_ready) begin
                    state_next = st_idle;
                end
            end
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (msg_in.valid && msg_in.ready) begin
            msg_q <= msg_in.msg;
        end
        // Captured once so host writes cannot disturb a pending reply
        if (state == st_exec) begin
            reply_payload <= write_state.user_state;
        end
    end

endmodule : dircc_device_core

// ==== verilog/dircc_msg_fifo.sv ====
`timescale 1ns/1ps

module dircc_msg_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  reset_n,

    input  logic                  in_valid,
    output logic                  in_ready,
    input  dircc_types_pkg::msg_t in_msg,

    dircc_msg_if.producer         deq
);

    import dircc_types_pkg::*;

    localparam int ptr_w = $clog2(FIFO_DEPTH);
    localparam int cnt_w = ptr_w + 1;

    msg_t             fifo_mem [FIFO_DEPTH];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic [cnt_w-1:0] count_next;
    logic             enq;
    logic             deq_fire;

    assign enq      = in_valid && in_ready;
    assign deq_fire = deq.valid && deq.ready;

    always_comb begin
        count_next = count + cnt_w'(enq) - cnt_w'(deq_fire);
    end

    // Head entry
    assign deq.valid = (count != '0);
    assign deq.msg   = fifo_mem[rd_ptr];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            in_ready <= 1'b0;   // Opens one cycle after reset
        end else begin
            if (enq) begin
                wr_ptr <= wr_ptr + 1'b1;   // Depth is a power of two
            end
            if (deq_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count    <= count_next;
            in_ready <= (count_next != cnt_w'(FIFO_DEPTH));
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (enq) begin
            fifo_mem[wr_ptr] <= in_msg;
        end
    end

endmodule : dircc_msg_fifo

// ==== verilog/dircc_msg_if.sv ====
`timescale 1ns/1ps

// Message channel, transfer on valid and ready
interface dircc_msg_if;

    import dircc_types_pkg::*;

    logic valid;
    logic ready;
    msg_t msg;     // Held with valid until the transfer

    modport producer (
        output valid,
        output msg,
        input  ready
    );

    modport consumer (
        input  valid,
        input  msg,
        output ready
    );

endinterface : dircc_msg_if

// ==== verilog/dircc_node.sv ====
`timescale 1ns/1ps

module dircc_node #(
    parameter int ADDRESS_WIDTH = 15,
    parameter int FIFO_DEPTH    = 4
) (
    input  logic                                      clk,
    input  logic                                      reset_n,

    // Message input
    input  logic                                      in_valid,
    output logic                                      in_ready,
    input  dircc_types_pkg::msg_op_t                  in_op,
    input  logic [dircc_types_pkg::src_width-1:0]     in_src,
    input  logic [dircc_types_pkg::payload_width-1:0] in_payload,

    // Reply output
    output logic                                      out_valid,
    input  logic                                      out_ready,
    output logic [dircc_types_pkg::src_width-1:0]     out_src,
    output logic [dircc_types_pkg::payload_width-1:0] out_payload,

    // Host port
    input  logic [ADDRESS_WIDTH-1:0]                  mem_address,
    input  logic                                      mem_write,
    input  logic [dircc_types_pkg::mem_width-1:0]     mem_writedata,
    output logic [dircc_types_pkg::mem_width-1:0]     mem_readdata
);

    import dircc_types_pkg::*;

    msg_t          in_msg;
    device_state_t read_state;
    device_state_t write_state;
    logic          write_state_valid;

    dircc_msg_if q_if ();   // Queue to core

    assign in_msg.op      = in_op;
    assign in_msg.src     = in_src;
    assign in_msg.payload = in_payload;

    dircc_msg_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_fifo (
        .clk      (clk),
        .reset_n  (reset_n),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_msg   (in_msg),
        .deq      (q_if.producer)
    );

    dircc_device_core i_core (
        .clk               (clk),
        .reset_n           (reset_n),
        .msg_in            (q_if.consumer),
        .read_state        (read_state),
        .write_state       (write_state),
        .write_state_valid (write_state_valid),
        .out_valid         (out_valid),
        .out_ready         (out_ready),
        .out_src           (out_src),
        .out_payload       (out_payload)
    );

    dircc_status_register #(
        .ADDRESS_WIDTH (ADDRESS_WIDTH)
    ) i_status (
        .clk               (clk),
        .reset_n           (reset_n),
        .mem_address       (mem_address),
        .mem_write         (mem_write),
        .mem_writedata     (mem_writedata),
        .mem_readdata      (mem_readdata),
        .read_state        (read_state),
        .write_state       (write_state),
        .write_state_valid (write_state_valid)
    );

endmodule : dircc_node

// ==== verilog/dircc_status_register.sv ====
`timescale 1ns/1ps

module dircc_status_register #(
    parameter int ADDRESS_WIDTH = 15
) (
    input  logic                                 clk,
    input  logic                                 reset_n,

    input  logic [ADDRESS_WIDTH-1:0]             mem_address,
    input  logic                                 mem_write,
    input  logic [dircc_types_pkg::mem_width-1:0] mem_writedata,
    output logic [dircc_types_pkg::mem_width-1:0] mem_readdata,

    output dircc_types_pkg::device_state_t       read_state,
    input  dircc_types_pkg::device_state_t       write_state,
    input  logic                                 write_state_valid
);

    import dircc_types_pkg::*;

    localparam int byte_aw = $clog2(dev_mem_bytes);

    logic [7:0]                 dev_mem [dev_mem_bytes];
    logic [8*dev_mem_bytes-1:0] store_flat;   // Byte array as one vector
    logic [8*dev_mem_bytes-1:0] wb_flat;      // Record from the core
    logic                       addr_ok;
    logic [byte_aw-1:0]         lo_idx;
    logic [byte_aw-1:0]         hi_idx;

    // Highest word address still inside the record
    assign addr_ok = (mem_address <= ADDRESS_WIDTH'(dev_mem_bytes - 2));
    assign lo_idx  = mem_address[byte_aw-1:0];
    assign hi_idx  = lo_idx + 1'b1;

    always_comb begin
        for (int i = 0; i < dev_mem_bytes; i++) begin
            store_flat[8*i +: 8] = dev_mem[i];
        end
    end

    assign {read_state.user_state, read_state.dircc_state_extra,
            read_state.dircc_state} = store_flat;

    assign wb_flat = {write_state.user_state, write_state.dircc_state_extra,
                      write_state.dircc_state};

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < dev_mem_bytes; i++) begin
                dev_mem[i] <= '0;
            end
            mem_readdata <= '0;
        end else begin
            if (write_state_valid) begin
                // Core write-back wins, host write dropped
                for (int i = 0; i < dev_mem_bytes; i++) begin
                    dev_mem[i] <= wb_flat[8*i +: 8];
                end
            end else if (mem_write && addr_ok) begin
                dev_mem[hi_idx] <= mem_writedata[15:8];
                dev_mem[lo_idx] <= mem_writedata[7:0];
            end

            // Registered read, old contents on a write cycle
            if (addr_ok) begin
                mem_readdata <= {dev_mem[hi_idx], dev_mem[lo_idx]};
            end else begin
                mem_readdata <= '0;
            end
        end
    end

endmodule : dircc_status_register

// ==== verilog/dircc_types_pkg.sv ====
package dircc_types_pkg;

    // Host memory port
    parameter int mem_width = 16;

    // State record size in bytes
    parameter int dev_mem_bytes = 12;

    // Message field widths
    parameter int src_width     = 16;
    parameter int payload_width = 64;

    // Device state record, little-endian in the status register
    // Bytes 0-1 count, 2-3 last src, 4-11 accumulator
    typedef struct packed {
        logic [15:0]              dircc_state;        // Messages executed
        logic [src_width-1:0]     dircc_state_extra;  // Src of last message
        logic [payload_width-1:0] user_state;         // Accumulator
    } device_state_t;

    typedef enum logic [1:0] {
        op_add   = 2'd0,
        op_max   = 2'd1,
        op_clear = 2'd2,
        op_read  = 2'd3
    } msg_op_t;

    typedef struct packed {
        msg_op_t                  op;
        logic [src_width-1:0]     src;
        logic [payload_width-1:0] payload;
    } msg_t;

    // Device core FSM
    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_exec = 2'd1,
        st_send = 2'd2
    } core_state_t;

endpackage : dircc_types_pkg
